//--- tb.f
sd_pkg.sv
sd_clk_gen.sv
sd_cmd_engine.sv
sd_dat_reader.sv
sd_host_ctrl.sv
sd_reader.sv
sd_card_model.sv
sd_reader_asserts.sv
tb_sd_reader.sv

//--- tb_sd_reader.sv
/* sd reader testbench */

`default_nettype none

module tb_sd_reader import sd_pkg::*; ();

    localparam int ROWS      = 4;
    localparam int ROW_LIMIT = 100000;   // clk cycles per table row

    typedef struct packed {
        logic        v1;
        logic        ccs;
        logic [31:0] sector;
        logic        suppress;
        card_type_e  exp_type;
        logic        exp_timeout;
    } row_t;

    logic         clk;
    logic         rstn;
    logic         init;
    logic         rstart;
    logic [31:0]  rsector;
    logic         sdclk;
    wire          sdcmd;
    logic         sddat0;
    host_state_e  card_stat;
    card_type_e   card_type;
    logic         rbusy;
    logic         rdone;
    logic         outen;
    sector_byte_t sector_byte;
    logic         timeout_error;

    logic         v1, ccs, suppress;
    logic [1:0]   busy_tries;
    row_t         table_rows [ROWS];
    int           cycles = 0;
    int           row_base = 0;
    int           row_idx = 0;

    pullup (sdcmd);

    sd_reader u_sd_reader (
        .clk(clk), .rstn(rstn), .sdclk(sdclk), .sdcmd(sdcmd), .sddat0(sddat0),
        .card_stat(card_stat), .card_type(card_type), .init(init), .rstart(rstart),
        .rsector(rsector), .rbusy(rbusy), .rdone(rdone), .outen(outen),
        .sector_byte(sector_byte), .timeout_error(timeout_error)
    );

    sd_card_model u_card (
        .sdclk(sdclk), .sdcmd(sdcmd), .sddat0(sddat0), .v1(v1), .ccs(ccs),
        .suppress(suppress), .busy_tries(busy_tries)
    );

    bind sd_reader sd_reader_asserts u_asserts (
        .clk(clk), .rstn(rstn), .rbusy(rbusy), .rdone(rdone), .outen(outen),
        .sector_byte(sector_byte), .card_stat(card_stat), .cmd_oe(cmd_oe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // run control and checking
    // --------------------------------------------------
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles - row_base > ROW_LIMIT) begin
            $display("watchdog: row %0d still running after %0d cycles", row_idx, ROW_LIMIT);
            abort_run();
        end else if (u_sd_reader.u_asserts.fail_cnt != 0) begin
            $display("a bound assertion on the reader failed");
            abort_run();
        end
    end

    // one CMD17 read, bytes checked against the card's data rule
    task automatic do_read(input logic [31:0] sector, input card_type_e ctype,
                           input logic exp_to);
        logic [31:0] a;
        logic [7:0]  exp_byte;
        int          nbytes;
        a      = (ctype == CARD_SDHC) ? sector : sector << 9;
        nbytes = 0;
        @(posedge clk);
        #1;
        rsector = sector;
        rstart  = 1'b1;
        @(posedge clk);
        #1;
        rstart = 1'b0;
        do begin
            @(negedge clk);
            if (outen) begin
                exp_byte = 8'(a[7:0] + a[15:8] + a[24:16] + nbytes);
                check_eq("sector_byte.addr", sector_byte.addr, nbytes);
                check_eq("sector_byte.data", sector_byte.data, exp_byte);
                nbytes++;
            end
        end while (!rdone);
        check_eq("outen count", nbytes, exp_to ? 0 : SECTOR_BYTES);
        check_eq("timeout_error", timeout_error, exp_to);
        check_eq("rbusy", rbusy, 0);
    endtask

    initial begin
        row_t row;
        rstn       = 1'b0;
        init       = 1'b0;
        rstart     = 1'b0;
        rsector    = '0;
        v1         = 1'b0;
        ccs        = 1'b0;
        suppress   = 1'b0;
        busy_tries = 2'd1;
        void'($urandom(99703));

        //               v1    ccs   sector        supp  type       timeout
        table_rows[0] = '{1'b1, 1'b0, 32'h0000_0005, 1'b0, CARD_SDV1, 1'b0};
        table_rows[1] = '{1'b0, 1'b0, 32'h0000_0033, 1'b0, CARD_SDV2, 1'b0};
        table_rows[2] = '{1'b0, 1'b1, 32'h0001_2345, 1'b0, CARD_SDHC, 1'b0};
        table_rows[3] = '{1'b0, 1'b1, 32'h0000_0077, 1'b1, CARD_SDHC, 1'b1};

        for (int r = 0; r < ROWS; r++) begin
            row = table_rows[r];
            @(posedge clk);
            #1;
            row_idx    = r;
            row_base   = cycles;
            rstn       = 1'b0;
            v1         = row.v1;
            ccs        = row.ccs;
            suppress   = row.suppress;
            busy_tries = 2'(1 + $urandom % 3);
            repeat (10) @(posedge clk);
            #1;
            check_eq("sdclk", sdclk, 0);
            check_eq("outen", outen, 0);
            check_eq("rdone", rdone, 0);
            rstn = 1'b1;

            // long enough for the start bit of a premature CMD0 to show
            repeat (2 * int'(SLOW_CLK_DIV) * (int'(INIT_PRECNT) + 16)) begin
                @(negedge clk);
                check_eq("sdcmd", sdcmd, 1);
                check_eq("rbusy", rbusy, 1);
                check_eq("card_stat", card_stat, ST_STANDBY);
                check_eq("card_type", card_type, CARD_UNKNOWN);
            end
            @(posedge clk);
            #1;
            init = 1'b1;
            @(posedge clk);
            #1;
            init = 1'b0;

            do @(negedge clk); while (card_stat != ST_IDLE);
            check_eq("card_type", card_type, row.exp_type);
            check_eq("rbusy", rbusy, 0);

            do_read(row.sector, row.exp_type, row.exp_timeout);
            if (row.suppress) begin
                @(posedge clk);
                #1;
                suppress = 1'b0;
                do_read(row.sector, row.exp_type, 1'b0);
            end
        end

        if (u_sd_reader.u_asserts.fail_cnt == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d bound assertion failures", u_sd_reader.u_asserts.fail_cnt);
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- sd_reader_asserts.sv
/* sd reader bound checks */

`default_nettype none

module sd_reader_asserts import sd_pkg::*; (
    input wire               clk,
    input wire               rstn,
    input wire               rbusy,
    input wire               rdone,
    input wire               outen,
    input wire sector_byte_t sector_byte,
    input wire host_state_e  card_stat,
    input wire               cmd_oe
);

    int         fail_cnt = 0;
    logic [8:0] last_addr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            last_addr <= 9'h1ff;     // so the first strobe must be address 0
        else if (outen)
            last_addr <= sector_byte.addr;
    end

    a_outen_in_read: assert property (@(posedge clk) disable iff (!rstn) outen |-> rbusy)
        else begin
            $error("outen strobe outside a read");
            fail_cnt++;
        end

    a_rdone_pulse: assert property (@(posedge clk) disable iff (!rstn) rdone |=> !rdone)
        else begin
            $error("rdone longer than one cycle");
            fail_cnt++;
        end

    a_addr_step: assert property (@(posedge clk) disable iff (!rstn)
                                  outen |-> sector_byte.addr == last_addr + 9'd1)
        else begin
            $error("sector byte address skipped");
            fail_cnt++;
        end

    a_standby_quiet: assert property (@(posedge clk) disable iff (!rstn)
                                      card_stat == ST_STANDBY |-> !cmd_oe)
        else begin
            $error("sdcmd driven in standby");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- sd_card_model.sv
/* behavioural sd card */

`default_nettype none

module sd_card_model import sd_pkg::*; (
    input  wire       sdclk,
    inout  wire       sdcmd,
    output logic      sddat0,
    input  wire       v1,          // silent to CMD8
    input  wire       ccs,
    input  wire       suppress,    // no data block after CMD17
    input  wire [1:0] busy_tries   // ACMD41 answers with busy set
);

    logic        cmd_oe;
    logic        cmd_out;
    logic [47:0] frame;
    int          busy_left;

    assign sdcmd = cmd_oe ? cmd_out : 1'bz;

    // wait for a start bit, then shift in the rest of the 48 bit command
    task automatic get_cmd();
        do @(posedge sdclk); while (sdcmd !== 1'b0);
        frame[47] = 1'b0;
        for (int i = 46; i >= 0; i--) begin
            @(posedge sdclk);
            frame[i] = sdcmd;
        end
    endtask

    task automatic send_bits(input logic [135:0] bits, input int n);
        repeat (2) @(negedge sdclk);   // host releases the line on the first
        cmd_oe = 1'b1;
        for (int i = n - 1; i >= 0; i--) begin
            cmd_out = bits[i];
            @(negedge sdclk);
        end
        cmd_oe  = 1'b0;
        cmd_out = 1'b1;
    endtask

    task automatic send_short(input logic [5:0] idx, input logic [31:0] a);
        send_bits({88'h0, 2'b00, idx, a, 7'h7f, 1'b1}, 48);
    endtask

    task automatic send_sector(input logic [31:0] a);
        logic [7:0] b;
        repeat (2) @(negedge sdclk);
        sddat0 = 1'b0;                 // start bit
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            b = 8'(a[7:0] + a[15:8] + a[24:16] + i);
            for (int k = 7; k >= 0; k--) begin
                @(negedge sdclk);
                sddat0 = b[k];
            end
        end
        repeat (TAIL_BITS) begin       // crc16 and end bit, sent as ones
            @(negedge sdclk);
            sddat0 = 1'b1;
        end
    endtask

    initial begin
        cmd_oe    = 1'b0;
        cmd_out   = 1'b1;
        sddat0    = 1'b1;
        busy_left = 0;
        forever begin
            get_cmd();
            case (frame[45:40])
                6'd0:  busy_left = busy_tries;             // go idle, no response
                6'd8:  if (!v1) send_short(6'd8, frame[39:8]);
                6'd41: begin
                    send_short(6'h3f, {busy_left == 0, ccs, 30'h00ff8000});
                    if (busy_left > 0)
                        busy_left--;
                end
                6'd2:  send_bits({2'b00, 6'h3f, 64'h0123_4567_89ab_cdef, 63'h0, 1'b1}, 136);
                6'd3:  send_short(6'd3, 32'h1234_0500);   // rca 0x1234
                6'd17: begin
                    send_short(6'd17, 32'h900);
                    if (!suppress)
                        send_sector(frame[39:8]);
                end
                default: send_short(frame[45:40], 32'h900);
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sd_reader.sv
/* sd card sector reader */

`default_nettype none

module sd_reader import sd_pkg::*; (
    input  wire          clk,
    input  wire          rstn,
    output logic         sdclk,
    inout  wire          sdcmd,
    input  wire          sddat0,
    output host_state_e  card_stat,
    output card_type_e   card_type,
    input  wire          init,
    input  wire          rstart,
    input  wire   [31:0] rsector,
    output logic         rbusy,
    output logic         rdone,
    output logic         outen,
    output sector_byte_t sector_byte,
    output logic         timeout_error
);

    logic      sd_rise, sd_fall, fast;
    logic      cmd_start, cmd_busy, cmd_done;
    cmd_req_t  cmd_req;
    cmd_resp_t cmd_resp;
    logic      cmd_out, cmd_oe;
    logic      dat_arm, dat_done, dat_timeout;

    assign sdcmd = cmd_oe ? cmd_out : 1'bz;   // released line is pulled up
    assign rbusy = (card_stat != ST_IDLE);

    sd_clk_gen u_clk_gen (
        .clk     (clk),
        .rstn    (rstn),
        .fast    (fast),
        .sdclk   (sdclk),
        .sd_rise (sd_rise),
        .sd_fall (sd_fall)
    );

    sd_cmd_engine u_cmd_engine (
        .clk       (clk),
        .rstn      (rstn),
        .sd_rise   (sd_rise),
        .sd_fall   (sd_fall),
        .cmd_start (cmd_start),
        .cmd_req   (cmd_req),
        .cmd_busy  (cmd_busy),
        .cmd_done  (cmd_done),
        .cmd_resp  (cmd_resp),
        .cmd_in    (sdcmd),
        .cmd_out   (cmd_out),
        .cmd_oe    (cmd_oe)
    );

    sd_host_ctrl u_host_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .init          (init),
        .rstart        (rstart),
        .rsector       (rsector),
        .cmd_busy      (cmd_busy),
        .cmd_done      (cmd_done),
        .cmd_resp      (cmd_resp),
        .cmd_start     (cmd_start),
        .cmd_req       (cmd_req),
        .dat_done      (dat_done),
        .dat_timeout   (dat_timeout),
        .dat_arm       (dat_arm),
        .fast          (fast),
        .card_stat     (card_stat),
        .card_type     (card_type),
        .rdone         (rdone),
        .timeout_error (timeout_error)
    );

    sd_dat_reader u_dat_reader (
        .clk         (clk),
        .rstn        (rstn),
        .sd_rise     (sd_rise),
        .dat_arm     (dat_arm),
        .dat0        (sddat0),
        .dat_done    (dat_done),
        .dat_timeout (dat_timeout),
        .outen       (outen),
        .sector_byte (sector_byte)
    );

endmodule

`default_nettype wire

//--- sd_host_ctrl.sv
/* sd card init and read control */

`default_nettype none

module sd_host_ctrl import sd_pkg::*; (
    input  wire         clk,
    input  wire         rstn,
    input  wire         init,
    input  wire         rstart,
    input  wire  [31:0] rsector,
    input  wire         cmd_busy,
    input  wire         cmd_done,
    input  wire         cmd_resp_t cmd_resp,
    output logic        cmd_start,
    output cmd_req_t    cmd_req,
    input  wire         dat_done,
    input  wire         dat_timeout,
    output logic        dat_arm,
    output logic        fast,
    output host_state_e card_stat,
    output card_type_e  card_type,
    output logic        rdone,
    output logic        timeout_error
);

    host_state_e state;
    logic        pending;     // command issued, no cmd_done yet
    logic        sdv1;        // CMD8 never answered
    logic [2:0]  cmd8_cnt;
    logic [15:0] rca;
    logic [31:0] read_addr;
    logic        resp_ok;

    assign card_stat = state;
    assign resp_ok   = !cmd_resp.timeout && !cmd_resp.syntax_err;

    function automatic cmd_req_t mk_req(input logic [5:0] idx, input logic [31:0] a,
                                        input logic [15:0] pre, input logic lng);
        return '{index: idx, arg: a, precnt: pre, long_resp: lng};
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state         <= ST_STANDBY;
            pending       <= 1'b0;
            sdv1          <= 1'b0;
            cmd8_cnt      <= '0;
            rca           <= '0;
            read_addr     <= '0;
            cmd_start     <= 1'b0;
            cmd_req       <= '0;
            dat_arm       <= 1'b0;
            fast          <= 1'b0;
            card_type     <= CARD_UNKNOWN;
            rdone         <= 1'b0;
            timeout_error <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            dat_arm   <= 1'b0;
            rdone     <= 1'b0;
            if (cmd_done) begin
                // --------------------------------------------------
                // response handling
                // --------------------------------------------------
                pending <= 1'b0;
                case (state)
                    ST_CMD0: state <= ST_CMD8;       // CMD0 has no response
                    ST_CMD8: if (resp_ok && cmd_resp.arg[7:0] == 8'haa) begin
                        state <= ST_CMD55;
                    end else if (cmd_resp.timeout) begin
                        cmd8_cnt <= cmd8_cnt + 3'd1;
                        if (cmd8_cnt == 3'(CMD8_RETRIES - 1)) begin
                            sdv1  <= 1'b1;
                            state <= ST_CMD55;
                        end
                    end
                    ST_CMD55: if (resp_ok) state <= ST_ACMD41;
                    ST_ACMD41: if (resp_ok && cmd_resp.arg[31]) begin
                        card_type <= sdv1 ? CARD_SDV1 :
                                     (cmd_resp.arg[30] ? CARD_SDHC : CARD_SDV2);
                        state     <= ST_CMD2;
                    end else begin
                        state <= ST_CMD55;           // card still busy
                    end
                    ST_CMD2: if (resp_ok) state <= ST_CMD3;
                    ST_CMD3: if (resp_ok) begin
                        rca   <= cmd_resp.arg[31:16];
                        state <= ST_CMD7;
                    end
                    ST_CMD7: if (resp_ok) begin
                        fast  <= 1'b1;
                        state <= (card_type == CARD_SDHC) ? ST_IDLE : ST_CMD16;
                    end
                    ST_CMD16: if (resp_ok) state <= ST_IDLE;
                    ST_READ_CMD: if (resp_ok) state <= ST_READ_DATA;  // else reissue
                    ST_STOP: begin
                        rdone <= 1'b1;
                        state <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;
                endcase
            end else if (!pending && !cmd_busy) begin
                case (state)
                    ST_STANDBY: if (init) state <= ST_CMD0;
                    ST_IDLE: if (rstart) begin
                        read_addr     <= (card_type == CARD_SDHC) ? rsector
                                                                  : {rsector[22:0], 9'b0};
                        timeout_error <= 1'b0;
                        state         <= ST_READ_CMD;
                    end
                    ST_READ_DATA: if (dat_done) begin
                        if (dat_timeout) begin
                            timeout_error <= 1'b1;
                            state         <= ST_STOP;      // cancel with CMD12
                        end else begin
                            rdone <= 1'b1;
                            state <= ST_IDLE;
                        end
                    end
                    default: begin
                        // --------------------------------------------------
                        // command issue for the current state
                        // --------------------------------------------------
                        cmd_start <= 1'b1;
                        pending   <= 1'b1;
                        case (state)
                            ST_CMD0:   cmd_req <= mk_req(6'd0, 32'h0, INIT_PRECNT, 1'b0);
                            ST_CMD8:   cmd_req <= mk_req(6'd8, 32'h1aa, CMD_PRECNT, 1'b0);
                            ST_CMD55:  cmd_req <= mk_req(6'd55, 32'h0, CMD_PRECNT, 1'b0);
                            ST_ACMD41: cmd_req <= mk_req(6'd41, {1'b0, !sdv1, 30'h00100000},
                                                         CMD_PRECNT, 1'b0);  // hcs unless v1
                            ST_CMD2:   cmd_req <= mk_req(6'd2, 32'h0, CMD_PRECNT, 1'b1);
                            ST_CMD3:   cmd_req <= mk_req(6'd3, 32'h0, CMD_PRECNT, 1'b0);
                            ST_CMD7:   cmd_req <= mk_req(6'd7, {rca, 16'h0}, CMD_PRECNT, 1'b0);
                            ST_CMD16:  cmd_req <= mk_req(6'd16, 32'h200, INIT_PRECNT, 1'b0);
                            ST_READ_CMD: begin
                                cmd_req <= mk_req(6'd17, read_addr, CMD_PRECNT, 1'b0);
                                dat_arm <= 1'b1;
                            end
                            default:   cmd_req <= mk_req(6'd12, 32'h0, CMD_PRECNT, 1'b0);
                        endcase
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- sd_dat_reader.sv
/* sd sector receiver */

`default_nettype none

module sd_dat_reader import sd_pkg::*; (
    input  wire          clk,
    input  wire          rstn,
    input  wire          sd_rise,
    input  wire          dat_arm,
    input  wire          dat0,
    output logic         dat_done,
    output logic         dat_timeout,
    output logic         outen,
    output sector_byte_t sector_byte
);

    typedef enum logic [1:0] {D_IDLE, D_WAIT, D_DATA, D_TAIL} dat_state_e;

    dat_state_e  state;
    logic [11:0] cnt;    // wait cycles, data bits or tail bits
    logic [6:0]  shift;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= D_IDLE;
            cnt         <= '0;
            shift       <= '0;
            dat_done    <= 1'b0;
            dat_timeout <= 1'b0;
            outen       <= 1'b0;
            sector_byte <= '0;
        end else begin
            dat_done <= 1'b0;
            outen    <= 1'b0;
            if (dat_arm) begin
                state <= D_WAIT;
                cnt   <= '0;
            end else if (sd_rise) begin
                case (state)
                    D_WAIT: if (!dat0) begin
                        cnt   <= '0;
                        state <= D_DATA;
                    end else if (cnt == 12'(DATA_TIMEOUT - 1)) begin
                        dat_done    <= 1'b1;
                        dat_timeout <= 1'b1;
                        state       <= D_IDLE;
                    end else begin
                        cnt <= cnt + 12'd1;
                    end
                    D_DATA: begin
                        shift <= {shift[5:0], dat0};
                        cnt   <= cnt + 12'd1;
                        if (cnt[2:0] == 3'd7) begin   // msb first
                            outen            <= 1'b1;
                            sector_byte.addr <= cnt[11:3];
                            sector_byte.data <= {shift, dat0};
                        end
                        if (cnt == 12'(SECTOR_BYTES * 8 - 1)) begin
                            cnt   <= '0;
                            state <= D_TAIL;
                        end
                    end
                    D_TAIL: if (cnt == 12'(TAIL_BITS - 1)) begin
                        dat_done    <= 1'b1;
                        dat_timeout <= 1'b0;
                        state       <= D_IDLE;
                    end else begin
                        cnt <= cnt + 12'd1;
                    end
                    default: state <= D_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- sd_cmd_engine.sv
/* sd command line engine */

`default_nettype none

module sd_cmd_engine import sd_pkg::*; (
    input  wire       clk,
    input  wire       rstn,
    input  wire       sd_rise,
    input  wire       sd_fall,
    input  wire       cmd_start,
    input  wire       cmd_req_t cmd_req,
    output logic      cmd_busy,
    output logic      cmd_done,
    output cmd_resp_t cmd_resp,
    input  wire       cmd_in,
    output logic      cmd_out,
    output logic      cmd_oe
);

    typedef enum logic [2:0] {
        E_IDLE, E_PRE, E_SEND, E_WAIT, E_RECV, E_DONE
    } eng_state_e;

    eng_state_e  state;
    cmd_req_t    req;
    logic [39:0] tx;     // start, transmission, index, argument
    logic [6:0]  crc;
    logic [46:0] rx;     // response bits after the start bit
    logic [15:0] cnt;
    logic        index_bad;

    // crc7, x^7 + x^3 + 1
    function automatic logic [6:0] crc7_next(input logic [6:0] c, input logic b);
        logic fb;
        fb = c[6] ^ b;
        return {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

    // R3 returns all ones in the index field
    assign index_bad = (rx[45:40] != req.index) &&
                       !(req.index == 6'd41 && rx[45:40] == 6'h3f);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= E_IDLE;
            req      <= '0;
            tx       <= '0;
            crc      <= '0;
            rx       <= '0;
            cnt      <= '0;
            cmd_busy <= 1'b0;
            cmd_done <= 1'b0;
            cmd_resp <= '0;
            cmd_out  <= 1'b1;
            cmd_oe   <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                E_IDLE: if (cmd_start) begin
                    req      <= cmd_req;
                    tx       <= {2'b01, cmd_req.index, cmd_req.arg};
                    crc      <= '0;
                    cnt      <= '0;
                    cmd_busy <= 1'b1;
                    state    <= E_PRE;
                end
                E_PRE: if (sd_fall) begin
                    cmd_oe  <= 1'b1;
                    cmd_out <= 1'b1;      // idle ones
                    if (cnt == req.precnt - 16'd1) begin
                        cnt   <= '0;
                        state <= E_SEND;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                E_SEND: if (sd_fall) begin
                    cnt <= cnt + 16'd1;
                    if (cnt < 16'd40) begin
                        cmd_out <= tx[39];
                        tx      <= {tx[38:0], 1'b0};
                        crc     <= crc7_next(crc, tx[39]);
                    end else if (cnt < 16'd47) begin
                        cmd_out <= crc[6];
                        crc     <= {crc[5:0], 1'b0};
                    end else if (cnt == 16'd47) begin
                        cmd_out <= 1'b1;  // end bit
                    end else begin
                        cmd_oe <= 1'b0;   // hand the line to the card
                        cnt    <= '0;
                        state  <= E_WAIT;
                    end
                end
                E_WAIT: if (sd_rise) begin
                    if (!cmd_in) begin
                        cnt   <= '0;
                        state <= E_RECV;
                    end else if (cnt == 16'(RESP_TIMEOUT - 1)) begin
                        cmd_busy <= 1'b0;
                        cmd_done <= 1'b1;
                        cmd_resp <= {1'b1, 1'b0, 32'h0};
                        state    <= E_IDLE;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                E_RECV: if (sd_rise) begin
                    rx  <= {rx[45:0], cmd_in};
                    cnt <= cnt + 16'd1;
                    if (cnt == (req.long_resp ? 16'd134 : 16'd46))
                        state <= E_DONE;
                end
                default: begin            // E_DONE
                    cmd_busy            <= 1'b0;
                    cmd_done            <= 1'b1;
                    cmd_resp.timeout    <= 1'b0;
                    cmd_resp.syntax_err <= !rx[0] || (!req.long_resp && index_bad);
                    cmd_resp.arg        <= rx[39:8];
                    state               <= E_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sd_clk_gen.sv
/* sd clock divider */

`default_nettype none

module sd_clk_gen import sd_pkg::*; (
    input  wire  clk,
    input  wire  rstn,
    input  wire  fast,
    output logic sdclk,
    output logic sd_rise,
    output logic sd_fall
);

    logic [15:0] cnt;
    logic [15:0] div;

    assign div = fast ? FAST_CLK_DIV : SLOW_CLK_DIV;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt     <= '0;
            sdclk   <= 1'b0;
            sd_rise <= 1'b0;
            sd_fall <= 1'b0;
        end else begin
            sd_rise <= 1'b0;
            sd_fall <= 1'b0;
            // >= so a switch to the fast rate mid-count cannot overrun
            if (cnt >= div - 16'd1) begin
                cnt     <= '0;
                sdclk   <= ~sdclk;
                sd_rise <= ~sdclk;
                sd_fall <= sdclk;
            end else begin
                cnt <= cnt + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sd_pkg.sv
/* sd host shared definitions */

`default_nettype none

package sd_pkg;

    // --------------------------------------------------
    // clocking and timing, sized for simulation
    // --------------------------------------------------
    localparam logic [15:0] SLOW_CLK_DIV = 16'd8;  // half sdclk period, identification
    localparam logic [15:0] FAST_CLK_DIV = 16'd2;  // half sdclk period after CMD7

    localparam int SECTOR_BYTES = 512;
    localparam int TAIL_BITS    = 17;      // crc16 plus end bit
    localparam int RESP_TIMEOUT = 64;      // sdclk cycles
    localparam int DATA_TIMEOUT = 2000;    // sdclk cycles
    localparam int CMD8_RETRIES = 8;

    localparam logic [15:0] INIT_PRECNT = 16'd80;
    localparam logic [15:0] CMD_PRECNT  = 16'd8;

    // --------------------------------------------------
    // types
    // --------------------------------------------------
    typedef enum logic [1:0] {
        CARD_UNKNOWN, CARD_SDV1, CARD_SDV2, CARD_SDHC
    } card_type_e;

    typedef enum logic [3:0] {
        ST_STANDBY, ST_CMD0, ST_CMD8, ST_CMD55, ST_ACMD41, ST_CMD2, ST_CMD3,
        ST_CMD7, ST_CMD16, ST_IDLE, ST_READ_CMD, ST_READ_DATA, ST_STOP
    } host_state_e;

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic [15:0] precnt;     // idle sdclk cycles before the frame
        logic        long_resp;  // 136 bit R2 response
    } cmd_req_t;

    typedef struct packed {
        logic        timeout;
        logic        syntax_err;  // bad end bit or index echo
        logic [31:0] arg;
    } cmd_resp_t;

    typedef struct packed {
        logic [8:0] addr;
        logic [7:0] data;
    } sector_byte_t;

endpackage

`default_nettype wire
